//--- src/uart_cmd_pkg.sv
package uart_cmd_pkg;

  typedef logic [15:0] cmd_t;       // bit 15 write flag, 14:8 register address, 7:0 data.
  typedef logic [7:0]  uart_byte_t;
  typedef logic [1:0]  wb_adr_t;
  typedef logic [15:0] wb_data_t;

  localparam int BIT_CYCLES         = 434;
  localparam int GAP_CYCLES         = 100;
  localparam int REPLY_TIMEOUT_BITS = 32;
  localparam int FIFO_DEPTH         = 4;
  localparam int FRAME_BITS         = 11;  // start, 8 data, parity, stop.

  localparam int BIT_CNT_W      = $clog2(BIT_CYCLES);
  localparam int GAP_CNT_W      = $clog2(GAP_CYCLES);
  localparam int TIMEOUT_CYCLES = REPLY_TIMEOUT_BITS * BIT_CYCLES;
  localparam int TIMEOUT_CNT_W  = $clog2(TIMEOUT_CYCLES);
  localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH + 1);

  localparam int STATUS_REPLY_VALID = 0;
  localparam int STATUS_PARITY_ERR  = 1;
  localparam int STATUS_TIMEOUT     = 2;
  localparam int STATUS_BUSY        = 3;
  localparam int STATUS_FIFO_FULL   = 4;

  localparam wb_adr_t ADR_CMD   = 2'd0;  // command on write, status on read.
  localparam wb_adr_t ADR_REPLY = 2'd1;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  // with done high the fields carry the outcome of a read.
  // With done low a set error field asks the port to clear that flag.
  typedef struct packed {
    logic       done;
    uart_byte_t data;
    logic       parity_err;
    logic       timeout;
  } read_result_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEAD,
    GAP,
    SEND_DATA,
    WAIT_REPLY,
    RECV_REPLY
  } engine_state_t;

endpackage

//--- src/uart_tx_frame.sv
module uart_tx_frame (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  uart_cmd_pkg::uart_byte_t data,
  output logic                     tx,
  output logic                     done
);

  logic                                  busy;
  logic [uart_cmd_pkg::FRAME_BITS-1:0]   frame;
  logic [3:0]                            bit_idx;
  logic [uart_cmd_pkg::BIT_CNT_W-1:0]    cnt;

  // the line is always the low end of the shift register, idle ones fill from the top.
  assign tx = frame[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame   <= '1;
      busy    <= 1'b0;
      done    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (!busy)
      begin
        if (start)
        begin
          busy    <= 1'b1;
          frame   <= {1'b1, ~^data, data, 1'b0};  // stop, odd parity, data, start.
          cnt     <= '0;
          bit_idx <= '0;
        end
      end
      else if (cnt == uart_cmd_pkg::BIT_CYCLES - 1)
      begin
        cnt   <= '0;
        frame <= {1'b1, frame[uart_cmd_pkg::FRAME_BITS-1:1]};
        if (bit_idx == uart_cmd_pkg::FRAME_BITS - 1)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- src/uart_rx_frame.sv
module uart_rx_frame (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     arm,
  input  logic                     rx,
  output logic                     started,
  output logic                     done,
  output uart_cmd_pkg::uart_byte_t data,
  output logic                     parity_err
);

  logic [2:0]                         sync;
  logic                               rx_s;
  logic                               fall;
  logic                               active;
  logic                               mid;
  logic                               parity_bit;
  logic [3:0]                         bit_idx;
  logic [uart_cmd_pkg::BIT_CNT_W-1:0] cnt;

  assign rx_s = sync[1];
  assign fall = sync[2] && !sync[1];
  assign mid  = active && (cnt == uart_cmd_pkg::BIT_CYCLES / 2 - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync    <= '1;
      active  <= 1'b0;
      started <= 1'b0;
      done    <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else
    begin
      sync    <= {sync[1:0], rx};
      started <= 1'b0;
      done    <= 1'b0;
      if (!active)
      begin
        if (arm && fall)
        begin
          active  <= 1'b1;
          cnt     <= '0;
          bit_idx <= '0;
        end
      end
      else
      begin
        if (cnt == uart_cmd_pkg::BIT_CYCLES - 1)
        begin
          cnt     <= '0;
          bit_idx <= bit_idx + 1'b1;
        end
        else
          cnt <= cnt + 1'b1;
        if (mid && bit_idx == '0)
        begin
          if (rx_s)
            active <= 1'b0;  // a glitch, not a start bit.
          else
            started <= 1'b1;
        end
        if (mid && bit_idx == uart_cmd_pkg::FRAME_BITS - 1)
        begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid)
    begin
      if (bit_idx inside {[1:8]})
        data <= {rx_s, data[7:1]};  // LSB arrives first.
      if (bit_idx == 4'd9)
        parity_bit <= rx_s;
      if (bit_idx == uart_cmd_pkg::FRAME_BITS - 1)
        parity_err <= ~^{data, parity_bit};
    end
  end

endmodule

//--- src/cmd_fifo.sv
module cmd_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               push,
  input  uart_cmd_pkg::cmd_t push_cmd,
  input  logic               pop,
  output uart_cmd_pkg::cmd_t head,
  output logic               full,
  output logic               empty
);

  uart_cmd_pkg::cmd_t                  mem [uart_cmd_pkg::FIFO_DEPTH];
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [uart_cmd_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [uart_cmd_pkg::FIFO_CNT_W-1:0] count;
  logic                                wr_en;
  logic                                rd_en;

  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == uart_cmd_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == uart_cmd_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave the fill level alone.
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_cmd;
  end

  assign head  = mem[rd_ptr];
  assign full  = (count == uart_cmd_pkg::FIFO_DEPTH);
  assign empty = (count == '0);

endmodule

//--- src/wb_cmd_port.sv
module wb_cmd_port (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::wb_req_t      wb_i,
  output uart_cmd_pkg::wb_rsp_t      wb_o,
  output logic                       push,
  output uart_cmd_pkg::cmd_t         push_cmd,
  input  logic                       full,
  input  logic                       busy,
  input  uart_cmd_pkg::read_result_t read_result
);

  logic                     req;
  logic                     cmd_wr;
  logic                     rd_reply;
  logic                     ack_d;
  logic                     ack_q;
  logic                     reply_valid;
  logic                     parity_flag;
  logic                     timeout_flag;
  uart_cmd_pkg::uart_byte_t reply;
  uart_cmd_pkg::wb_data_t   status;
  uart_cmd_pkg::wb_data_t   rd_dat;
  uart_cmd_pkg::wb_data_t   dat_q;

  assign req      = wb_i.cyc && wb_i.stb;
  assign cmd_wr   = req && wb_i.we && (wb_i.adr == uart_cmd_pkg::ADR_CMD);
  assign rd_reply = ack_d && !wb_i.we && (wb_i.adr == uart_cmd_pkg::ADR_REPLY);

  // a command write holds off its ack until the FIFO has room.
  assign ack_d = req && !ack_q && !(cmd_wr && full);

  always_comb
  begin
    status = '0;
    status[uart_cmd_pkg::STATUS_REPLY_VALID] = reply_valid;
    status[uart_cmd_pkg::STATUS_PARITY_ERR]  = parity_flag;
    status[uart_cmd_pkg::STATUS_TIMEOUT]     = timeout_flag;
    status[uart_cmd_pkg::STATUS_BUSY]        = busy;
    status[uart_cmd_pkg::STATUS_FIFO_FULL]   = full;
  end

  assign rd_dat = (wb_i.adr == uart_cmd_pkg::ADR_REPLY) ? {8'h00, reply} : status;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
      push  <= 1'b0;
    end
    else
    begin
      ack_q <= ack_d;
      push  <= ack_d && cmd_wr;  // lands together with the ack.
    end
  end

  always_ff @(posedge clk)
  begin
    if (ack_d && cmd_wr)
      push_cmd <= wb_i.dat;
    if (ack_d && !wb_i.we)
      dat_q <= rd_dat;
    if (read_result.done && !read_result.timeout)
      reply <= read_result.data;  // a reply with bad parity is still stored.
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reply_valid  <= 1'b0;
      parity_flag  <= 1'b0;
      timeout_flag <= 1'b0;
    end
    else
    begin
      if (rd_reply)
        reply_valid <= 1'b0;
      if (read_result.done)
      begin
        reply_valid  <= !read_result.parity_err && !read_result.timeout;
        parity_flag  <= read_result.parity_err;
        timeout_flag <= read_result.timeout;
      end
      else
      begin
        if (read_result.parity_err)
          parity_flag <= 1'b0;
        if (read_result.timeout)
          timeout_flag <= 1'b0;
      end
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = dat_q;

endmodule

//--- src/uart_cmd_engine.sv
module uart_cmd_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       empty,
  input  uart_cmd_pkg::cmd_t         head,
  output logic                       pop,
  output logic                       busy,
  output uart_cmd_pkg::read_result_t read_result,
  output logic                       tx,
  input  logic                       rx
);

  uart_cmd_pkg::engine_state_t            state;
  uart_cmd_pkg::cmd_t                     cmd_q;
  uart_cmd_pkg::uart_byte_t               tx_byte;
  uart_cmd_pkg::uart_byte_t               rx_byte;
  logic                                   tx_start;
  logic                                   tx_done;
  logic                                   rx_arm;
  logic                                   rx_started;
  logic                                   rx_done;
  logic                                   rx_parity_err;
  logic [uart_cmd_pkg::GAP_CNT_W-1:0]     gap_cnt;
  logic [uart_cmd_pkg::TIMEOUT_CNT_W-1:0] wait_cnt;

  assign pop    = (state == uart_cmd_pkg::IDLE) && !empty;
  // stays high while the result pulse is on its way to the status flags.
  assign busy   = (state != uart_cmd_pkg::IDLE) || read_result.done;
  assign rx_arm = (state == uart_cmd_pkg::WAIT_REPLY);

  // header frame is {write flag, address}; the data byte follows only on writes.
  assign tx_byte = (state == uart_cmd_pkg::SEND_DATA) ? cmd_q[7:0] : cmd_q[15:8];

  always_ff @(posedge clk)
  begin
    if (pop)
      cmd_q <= head;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= uart_cmd_pkg::IDLE;
      tx_start    <= 1'b0;
      read_result <= '0;
      gap_cnt     <= '0;
      wait_cnt    <= '0;
    end
    else
    begin
      tx_start    <= 1'b0;
      read_result <= '0;
      case (state)
        uart_cmd_pkg::IDLE:
        begin
          if (!empty)
          begin
            state    <= uart_cmd_pkg::SEND_HEAD;
            tx_start <= 1'b1;
            if (!head[15])
            begin
              read_result.parity_err <= 1'b1;  // clears both error flags.
              read_result.timeout    <= 1'b1;
            end
          end
        end
        uart_cmd_pkg::SEND_HEAD:
        begin
          gap_cnt  <= '0;
          wait_cnt <= '0;
          if (tx_done)
            state <= cmd_q[15] ? uart_cmd_pkg::GAP : uart_cmd_pkg::WAIT_REPLY;
        end
        uart_cmd_pkg::GAP:
        begin
          if (gap_cnt == uart_cmd_pkg::GAP_CYCLES - 1)
          begin
            state    <= uart_cmd_pkg::SEND_DATA;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        uart_cmd_pkg::SEND_DATA:
        begin
          if (tx_done)
            state <= uart_cmd_pkg::IDLE;
        end
        uart_cmd_pkg::WAIT_REPLY:
        begin
          if (rx_started)
            state <= uart_cmd_pkg::RECV_REPLY;
          else if (wait_cnt == uart_cmd_pkg::TIMEOUT_CYCLES - 1)
          begin
            state               <= uart_cmd_pkg::IDLE;
            read_result.done    <= 1'b1;
            read_result.timeout <= 1'b1;
          end
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        uart_cmd_pkg::RECV_REPLY:
        begin
          if (rx_done)
          begin
            state                  <= uart_cmd_pkg::IDLE;
            read_result.done       <= 1'b1;
            read_result.data       <= rx_byte;
            read_result.parity_err <= rx_parity_err;
          end
        end
        default: state <= uart_cmd_pkg::IDLE;
      endcase
    end
  end

  uart_tx_frame i_uart_tx_frame (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .tx    (tx),
    .done  (tx_done)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .arm        (rx_arm),
    .rx         (rx),
    .started    (rx_started),
    .done       (rx_done),
    .data       (rx_byte),
    .parity_err (rx_parity_err)
  );

endmodule

//--- src/uart_cmd_bridge.sv
module uart_cmd_bridge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  uart_cmd_pkg::wb_req_t wb_i,
  output uart_cmd_pkg::wb_rsp_t wb_o,
  output logic                  tx,
  input  logic                  rx
);

  logic                       push;
  logic                       pop;
  logic                       full;
  logic                       empty;
  logic                       busy;
  uart_cmd_pkg::cmd_t         push_cmd;
  uart_cmd_pkg::cmd_t         head;
  uart_cmd_pkg::read_result_t read_result;

  wb_cmd_port i_wb_cmd_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .push        (push),
    .push_cmd    (push_cmd),
    .full        (full),
    .busy        (busy),
    .read_result (read_result)
  );

  cmd_fifo i_cmd_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .push_cmd (push_cmd),
    .pop      (pop),
    .head     (head),
    .full     (full),
    .empty    (empty)
  );

  uart_cmd_engine i_uart_cmd_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (empty),
    .head        (head),
    .pop         (pop),
    .busy        (busy),
    .read_result (read_result),
    .tx          (tx),
    .rx          (rx)
  );

endmodule

//--- bench/uart_cmd_bridge_asserts.sv
module uart_cmd_bridge_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input uart_cmd_pkg::wb_req_t wb_i,
  input uart_cmd_pkg::wb_rsp_t wb_o,
  input logic                  tx
);

  int   fail_count = 0;
  logic cmd_seen;  // set once the port has taken its first command.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cmd_seen <= 1'b0;
    else if (wb_o.ack && wb_i.we && wb_i.adr == uart_cmd_pkg::ADR_CMD)
      cmd_seen <= 1'b1;
  end

  ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.ack |-> wb_i.cyc && wb_i.stb)
  else
  begin
    fail_count++;
    $error("ack rose without cyc and stb");
  end

  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.ack |=> !wb_o.ack)
  else
  begin
    fail_count++;
    $error("ack lasted two cycles");
  end

  tx_idle_until_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_seen |-> tx)
  else
  begin
    fail_count++;
    $error("tx left idle before any command was accepted");
  end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_asserts i_uart_cmd_bridge_asserts (
  .clk   (clk),
  .rst_n (rst_n),
  .wb_i  (wb_i),
  .wb_o  (wb_o),
  .tx    (tx)
);

//--- bench/tb_uart_cmd_bridge.sv
module tb_uart_cmd_bridge;

  localparam int CLK_PERIOD   = 40;
  localparam int TEST_FRAMES  = 21;  // frames on tx and rx summed over all tests.
  localparam int FRAME_CYCLES = uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::BIT_CYCLES;
  localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;
  localparam int HALF_BIT     = uart_cmd_pkg::BIT_CYCLES / 2;

  // the margin covers one reply timeout and the gaps between frames.
  localparam longint WATCHDOG_CYCLES =
    longint'(TEST_FRAMES + 8) * FRAME_CYCLES + uart_cmd_pkg::TIMEOUT_CYCLES;

  logic                  clk;
  logic                  rst_n;
  logic                  rx;
  logic                  tx;
  uart_cmd_pkg::wb_req_t wb_req;
  uart_cmd_pkg::wb_rsp_t wb_rsp;

  uart_cmd_bridge i_uart_cmd_bridge (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_i  (wb_req),
    .wb_o  (wb_rsp),
    .tx    (tx),
    .rx    (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error("watchdog expired before the tests finished");
  end

  initial
  begin
    wait (i_uart_cmd_bridge.i_uart_cmd_bridge_asserts.fail_count != 0);
    stop_on_error("a bound assertion on the bridge ports failed");
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input uart_cmd_pkg::uart_byte_t got,
                            input uart_cmd_pkg::uart_byte_t exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input uart_cmd_pkg::wb_data_t got,
                            input uart_cmd_pkg::wb_data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
  endtask

  // status word of an idle bridge with an empty FIFO.
  function automatic uart_cmd_pkg::wb_data_t status_when_idle(input logic valid,
                                                              input logic perr,
                                                              input logic tmo);
    uart_cmd_pkg::wb_data_t w;
    w = '0;
    w[uart_cmd_pkg::STATUS_REPLY_VALID] = valid;
    w[uart_cmd_pkg::STATUS_PARITY_ERR]  = perr;
    w[uart_cmd_pkg::STATUS_TIMEOUT]     = tmo;
    return w;
  endfunction

  task automatic wait_for_ack(output int cycles, output uart_cmd_pkg::wb_data_t dat);
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        stop_on_error("the Wishbone slave never acknowledged the cycle");
    end
    while (!wb_rsp.ack);
    dat = wb_rsp.dat;
    @(negedge clk);  // stb stays up through the whole ack cycle.
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_write(input uart_cmd_pkg::wb_adr_t adr, input uart_cmd_pkg::wb_data_t dat,
                          output int cycles);
    uart_cmd_pkg::wb_data_t unused;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wait_for_ack(cycles, unused);
  endtask

  task automatic wb_read(input uart_cmd_pkg::wb_adr_t adr, output uart_cmd_pkg::wb_data_t dat);
    int cycles;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wait_for_ack(cycles, dat);
  endtask

  task automatic poll_until_idle(output uart_cmd_pkg::wb_data_t status);
    int polls;
    polls = 0;
    do
    begin
      wb_read(uart_cmd_pkg::ADR_CMD, status);
      polls++;
      if (polls > WAIT_LIMIT)
        stop_on_error("the engine never went idle");
    end
    while (status[uart_cmd_pkg::STATUS_BUSY]);
  endtask

  // idle counts the falling edges up to the one that sees the start bit.
  task automatic receive_frame(output uart_cmd_pkg::uart_byte_t data, output int idle);
    logic parity;
    logic stop;
    idle = 0;
    do
    begin
      @(negedge clk);
      idle++;
      if (idle > WAIT_LIMIT)
        stop_on_error("no frame started on tx");
    end
    while (tx);
    repeat (HALF_BIT) @(negedge clk);
    if (tx !== 1'b0)
      stop_on_error("the tx start bit did not last to mid-bit");
    for (int i = 0; i < 8; i++)
    begin
      repeat (uart_cmd_pkg::BIT_CYCLES) @(negedge clk);
      data[i] = tx;
    end
    repeat (uart_cmd_pkg::BIT_CYCLES) @(negedge clk);
    parity = tx;
    repeat (uart_cmd_pkg::BIT_CYCLES) @(negedge clk);
    stop = tx;
    if (^{data, parity} !== 1'b1)
      stop_on_error("a tx frame does not have odd parity");
    if (stop !== 1'b1)
      stop_on_error("a tx frame has a low stop bit");
  endtask

  task automatic send_frame(input uart_cmd_pkg::uart_byte_t data, input logic good_parity);
    logic [uart_cmd_pkg::FRAME_BITS-1:0] bits;
    bits = {1'b1, good_parity ? ~^data : ^data, data, 1'b0};
    @(negedge clk);
    for (int i = 0; i < uart_cmd_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (uart_cmd_pkg::BIT_CYCLES) @(negedge clk);
    end
  endtask

  // the engine listens only after its header has left, so the device waits a bit first.
  task automatic answer_read(input uart_cmd_pkg::uart_byte_t data, input logic good_parity);
    repeat (uart_cmd_pkg::BIT_CYCLES) @(negedge clk);
    send_frame(data, good_parity);
  endtask

  task automatic start_read();
    logic [6:0]               reg_adr;
    uart_cmd_pkg::uart_byte_t got;
    int                       cycles;
    int                       idle;
    reg_adr = 7'($urandom());
    wb_write(uart_cmd_pkg::ADR_CMD, {1'b0, reg_adr, 8'h00}, cycles);
    receive_frame(got, idle);
    check_byte("tx header", got, {1'b0, reg_adr});
  endtask

  task automatic test_reset();
    uart_cmd_pkg::wb_data_t status;
    repeat (2)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("wb_o.ack", wb_rsp.ack, 1'b0);
    end
    rst_n = 1'b1;  // two rising edges have seen reset.
    repeat (2)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("wb_o.ack", wb_rsp.ack, 1'b0);
    end
    wb_read(uart_cmd_pkg::ADR_CMD, status);
    check_word("status", status, '0);
  endtask

  task automatic test_write();
    logic [6:0]               reg_adr;
    uart_cmd_pkg::uart_byte_t data;
    uart_cmd_pkg::uart_byte_t got;
    uart_cmd_pkg::wb_data_t   status;
    int                       cycles;
    int                       idle;
    reg_adr = 7'($urandom());
    data    = 8'($urandom());
    wb_write(uart_cmd_pkg::ADR_CMD, {1'b1, reg_adr, data}, cycles);
    receive_frame(got, idle);
    check_byte("tx header", got, {1'b1, reg_adr});
    receive_frame(got, idle);
    check_byte("tx data", got, data);
    if (idle - (uart_cmd_pkg::BIT_CYCLES - HALF_BIT) < uart_cmd_pkg::GAP_CYCLES)
      stop_on_error("the gap between the two write frames is too short");
    poll_until_idle(status);
    check_word("status", status, status_when_idle(1'b0, 1'b0, 1'b0));
  endtask

  task automatic test_read_good();
    uart_cmd_pkg::uart_byte_t reply;
    uart_cmd_pkg::wb_data_t   status;
    reply = 8'($urandom());
    start_read();
    answer_read(reply, 1'b1);
    poll_until_idle(status);
    check_word("status", status, status_when_idle(1'b1, 1'b0, 1'b0));
    wb_read(uart_cmd_pkg::ADR_REPLY, status);
    check_word("reply data", status, {8'h00, reply});
    wb_read(uart_cmd_pkg::ADR_CMD, status);
    check_word("status", status, status_when_idle(1'b0, 1'b0, 1'b0));
  endtask

  task automatic test_read_bad_parity();
    uart_cmd_pkg::wb_data_t status;
    start_read();
    answer_read(8'($urandom()), 1'b0);
    poll_until_idle(status);
    check_bit("status parity error", status[uart_cmd_pkg::STATUS_PARITY_ERR], 1'b1);
    check_bit("status reply valid", status[uart_cmd_pkg::STATUS_REPLY_VALID], 1'b0);
  endtask

  task automatic test_read_timeout();
    uart_cmd_pkg::wb_data_t status;
    start_read();
    poll_until_idle(status);
    check_bit("status timeout", status[uart_cmd_pkg::STATUS_TIMEOUT], 1'b1);
    check_bit("status reply valid", status[uart_cmd_pkg::STATUS_REPLY_VALID], 1'b0);
    start_read();
    wb_read(uart_cmd_pkg::ADR_CMD, status);
    check_bit("status timeout", status[uart_cmd_pkg::STATUS_TIMEOUT], 1'b0);
    check_bit("status busy", status[uart_cmd_pkg::STATUS_BUSY], 1'b1);
    answer_read(8'($urandom()), 1'b1);
    poll_until_idle(status);
    check_word("status", status, status_when_idle(1'b1, 1'b0, 1'b0));
  endtask

  task automatic test_back_pressure();
    uart_cmd_pkg::cmd_t       cmds [uart_cmd_pkg::FIFO_DEPTH + 2];
    uart_cmd_pkg::wb_data_t   status;
    uart_cmd_pkg::uart_byte_t got;
    int                       cycles;
    int                       max_cycles;
    int                       idle;
    max_cycles = 0;
    foreach (cmds[i])
      cmds[i] = {1'b1, 15'($urandom())};
    fork
      begin
        foreach (cmds[i])
        begin
          wb_write(uart_cmd_pkg::ADR_CMD, cmds[i], cycles);
          if (cycles > max_cycles)
            max_cycles = cycles;
          if (i == uart_cmd_pkg::FIFO_DEPTH)
          begin
            // the first command is in the engine and the rest fill the FIFO.
            wb_read(uart_cmd_pkg::ADR_CMD, status);
            check_bit("status fifo full", status[uart_cmd_pkg::STATUS_FIFO_FULL], 1'b1);
          end
        end
      end
      begin
        foreach (cmds[i])
        begin
          receive_frame(got, idle);
          check_byte("tx header", got, cmds[i][15:8]);
          receive_frame(got, idle);
          check_byte("tx data", got, cmds[i][7:0]);
        end
      end
    join
    check_bit("write ack delayed", max_cycles > 1, 1'b1);
    poll_until_idle(status);
  endtask

  initial
  begin
    void'($urandom(78));
    rst_n  = 1'b0;
    rx     = 1'b1;
    wb_req = '0;
    test_reset();
    test_write();
    test_read_good();
    test_read_bad_parity();
    test_read_timeout();
    test_back_pressure();
    if (i_uart_cmd_bridge.i_uart_cmd_bridge_asserts.fail_count == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      stop_on_error("a bound assertion on the bridge ports failed");
  end

endmodule

//--- filelist.f
src/uart_cmd_pkg.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/cmd_fifo.sv
src/wb_cmd_port.sv
src/uart_cmd_engine.sv
src/uart_cmd_bridge.sv
bench/uart_cmd_bridge_asserts.sv
bench/tb_uart_cmd_bridge.sv

//--- Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - target: rtl
    files:
      - src/uart_cmd_pkg.sv
      - src/uart_tx_frame.sv
      - src/uart_rx_frame.sv
      - src/cmd_fifo.sv
      - src/wb_cmd_port.sv
      - src/uart_cmd_engine.sv
      - src/uart_cmd_bridge.sv
  - target: test
    files:
      - bench/uart_cmd_bridge_asserts.sv
      - bench/tb_uart_cmd_bridge.sv
